/* design/renamePkg.sv */
`default_nettype none

package renamePkg;

    // architectural register number, r0 is hardwired to zero
    typedef logic [4:0] regIdxT;

    // instruction tag, 0 is reserved for "no pending writer"
    typedef logic [5:0] tagT;

    // register value
    typedef logic [31:0] dataT;

    // last tag handed out before the counter wraps back to 1
    localparam tagT maxTag = 6'd63;

    // one issue slot per cycle
    // dest of 0 means the instruction writes no register
    typedef struct packed {
        logic   valid;
        regIdxT dest;
    } issueReqT;

    // execution result, arrives out of program order
    typedef struct packed {
        logic valid;
        tagT  tag;
        dataT data;
    } doneT;

    // in-order retirement from the reorder buffer into the alias table
    typedef struct packed {
        logic   valid;
        regIdxT dest;
        tagT    tag;
        dataT   data;
    } commitT;

    // read port answer
    // tag is 0 when the value is ready to use
    typedef struct packed {
        dataT data;
        tagT  tag;
    } readRespT;

endpackage

`default_nettype wire

/* design/regAliasTable.sv */
`timescale 1ns/1ps
`default_nettype none

module regAliasTable #(
    parameter int numRead = 2
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire renamePkg::issueReqT issue,
    input  wire renamePkg::commitT   commit,
    input  wire renamePkg::regIdxT   readReg [numRead],
    output renamePkg::readRespT      readResp [numRead],
    output renamePkg::tagT           issueTag
);
    import renamePkg::*;

    localparam int numRegs = 32;

    // per-register rename state
    // avail set means value is architectural and tag is stale
    typedef struct packed {
        logic avail;
        tagT  tag;
        dataT value;
    } ratEntryT;

    ratEntryT regs [numRegs];

    // commit decode
    logic commitWrite;
    logic commitClears;

    // issue decode
    logic issueWrite;

    // tag counter successor
    tagT nextTag;

    // r0 is never written so it keeps its reset state forever
    assign commitWrite = commit.valid && (commit.dest != '0);

    // only the youngest writer of a register may release it
    // an older commit still lands its value, but the reg stays pending
    assign commitClears = commitWrite && (commit.tag == regs[commit.dest].tag);

    assign issueWrite = issue.valid && (issue.dest != '0);

    // skip tag 0, it means "no pending writer"
    assign nextTag = (issueTag == maxTag) ? tagT'(1) : issueTag + tagT'(1);

    // combinational read ports, they show state from before the edge
    always_comb begin
        for (int r = 0; r < numRead; r++) begin
            readResp[r].data = regs[readReg[r]].value;
            // pending regs report the tag to wait for
            readResp[r].tag = regs[readReg[r]].avail ? tagT'(0) : regs[readReg[r]].tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // every reg architectural and zero after reset
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= ratEntryT'{avail: 1'b1, tag: '0, value: '0};
            end
            issueTag <= tagT'(1);
        end else begin
            // commit first
            if (commitWrite) begin
                regs[commit.dest].value <= commit.data;
                if (commitClears) begin
                    regs[commit.dest].avail <= 1'b1;
                end
            end

            // issue second, so a same-cycle issue to the committed reg
            // overrides the avail bit and leaves it pending on the new tag
            if (issueWrite) begin
                regs[issue.dest].avail <= 1'b0;
                regs[issue.dest].tag <= issueTag;
            end

            // every issue consumes a tag, even with no destination,
            // since the reorder buffer still tracks it
            if (issue.valid) begin
                issueTag <= nextTag;
            end
        end
    end

    // the reorder buffer filters out r0 writers before commit
    commitNeverR0: assert property (
        @(posedge clk) disable iff (rst)
        commit.valid |-> (commit.dest != '0)
    );

endmodule

`default_nettype wire

/* design/reorderBuffer.sv */
`timescale 1ns/1ps
`default_nettype none

module reorderBuffer #(
    parameter int robDepth = 8
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire renamePkg::issueReqT issue,
    input  wire renamePkg::tagT      issueTag,
    input  wire renamePkg::doneT     done,
    output renamePkg::commitT        commit,
    output logic                     robFull
);
    import renamePkg::*;

    localparam int ptrW = (robDepth > 1) ? $clog2(robDepth) : 1;
    localparam int cntW = $clog2(robDepth + 1);

    typedef logic [ptrW-1:0] ptrT;
    typedef logic [cntW-1:0] cntT;

    // payload of one in-flight instruction
    typedef struct packed {
        regIdxT dest;
        tagT    tag;
        dataT   value;
    } robEntryT;

    robEntryT entries [robDepth];

    // per-slot control bits
    logic [robDepth-1:0] occupied;
    logic [robDepth-1:0] complete;

    // associative tag match for the done strobe
    logic [robDepth-1:0] doneMatch;

    ptrT headPtr;
    ptrT tailPtr;
    cntT count;

    logic push;
    logic retire;

    // circular increment, depth need not be a power of two
    function automatic ptrT nextPtr(input ptrT p);
        return (p == ptrT'(robDepth - 1)) ? ptrT'(0) : p + ptrT'(1);
    endfunction

    assign push = issue.valid;

    // head leaves as soon as its result is in
    assign retire = occupied[headPtr] && complete[headPtr];

    assign robFull = (count == cntT'(robDepth));

    // search all live, unfinished entries for the finishing tag
    always_comb begin
        for (int i = 0; i < robDepth; i++) begin
            doneMatch[i] = done.valid && occupied[i] && !complete[i]
                           && (entries[i].tag == done.tag);
        end
    end

    // commit straight from the head slot
    // no-destination entries still pop, just without a table write
    always_comb begin
        commit.valid = retire && (entries[headPtr].dest != '0);
        commit.dest = entries[headPtr].dest;
        commit.tag = entries[headPtr].tag;
        commit.data = entries[headPtr].value;
    end

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= '0;
            complete <= '0;
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            // a match never hits the head while it retires, since
            // only incomplete entries match
            for (int i = 0; i < robDepth; i++) begin
                if (doneMatch[i]) begin
                    complete[i] <= 1'b1;
                end
            end

            if (retire) begin
                occupied[headPtr] <= 1'b0;
                complete[headPtr] <= 1'b0;
                headPtr <= nextPtr(headPtr);
            end

            // tail slot is free here, the issuer holds off while full
            if (push) begin
                occupied[tailPtr] <= 1'b1;
                complete[tailPtr] <= 1'b0;
                tailPtr <= nextPtr(tailPtr);
            end

            case ({push, retire})
                2'b10:   count <= count + cntT'(1);
                2'b01:   count <= count - cntT'(1);
                default: count <= count;
            endcase
        end
    end

    // payload, written on issue and on completion only
    always_ff @(posedge clk) begin
        for (int i = 0; i < robDepth; i++) begin
            if (doneMatch[i]) begin
                entries[i].value <= done.data;
            end
        end
        if (push) begin
            entries[tailPtr].dest <= issue.dest;
            entries[tailPtr].tag <= issueTag;
        end
    end

    // back-pressure is a level, the issuer must honor it
    noIssueWhenFull: assert property (
        @(posedge clk) disable iff (rst)
        robFull |-> !issue.valid
    );

    // done must name exactly one outstanding instruction
    doneTagUnique: assert property (
        @(posedge clk) disable iff (rst)
        done.valid |-> $onehot(doneMatch)
    );

endmodule

`default_nettype wire

/* design/renameCore.sv */
`timescale 1ns/1ps
`default_nettype none

module renameCore #(
    parameter int numRead  = 2,
    parameter int robDepth = 8
) (
    input  wire logic                clk,
    input  wire logic                rst,
    // issue and completion strobes
    input  wire renamePkg::issueReqT issue,
    input  wire renamePkg::doneT     done,
    // operand lookup
    input  wire renamePkg::regIdxT   readReg [numRead],
    output renamePkg::readRespT      readResp [numRead],
    // tag the next issue will get
    output renamePkg::tagT           issueTag,
    // level, no issue allowed while high
    output logic                     robFull
);
    import renamePkg::*;

    // in-order retirement from buffer into table
    commitT commit;

    // alias table owns the tag counter
    // both blocks see the same issue strobe
    regAliasTable #(
        .numRead (numRead)
    ) ratInst (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .commit   (commit),
        .readReg  (readReg),
        .readResp (readResp),
        .issueTag (issueTag)
    );

    // buffer latches issueTag with the destination into its tail slot
    reorderBuffer #(
        .robDepth (robDepth)
    ) robInst (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .issueTag (issueTag),
        .done     (done),
        .commit   (commit),
        .robFull  (robFull)
    );

endmodule

`default_nettype wire

/* sim/renameCoreTests.svh */
// every reg zero and available, counter at 1, buffer empty
task automatic resetState();
    for (int r = 0; r < 32; r++) begin
        idle(1);
        expectReg("resetState", regIdxT'(r), '0, '0);
    end
    checkEq("resetState", "issueTag", 32'd1, 32'(issueTag));
    checkEq("resetState", "robFull", 32'd0, 32'(robFull));
endtask

task automatic issueAndCommit();
    tagT  t;
    dataT v;
    v = $urandom;
    issueOne("issueAndCommit", 5'd5, t);
    expectReg("issueAndCommit", 5'd5, '0, t);
    completeTag(t, v);
    // done edge just passed, commit is one edge away
    expectReg("issueAndCommit", 5'd5, '0, t);
    idle(1);
    expectReg("issueAndCommit", 5'd5, v, '0);
    checkStatus("issueAndCommit");
endtask

task automatic outOfOrderDone();
    tagT  tags [4];
    dataT vals [4];
    for (int i = 0; i < 4; i++) begin
        vals[i] = $urandom;
        issueOne("outOfOrderDone", regIdxT'(10 + i), tags[i]);
    end
    // youngest first, nothing may retire while the oldest is out
    for (int i = 3; i > 0; i--) begin
        completeTag(tags[i], vals[i]);
        for (int j = 0; j < 4; j++) begin
            expectReg("outOfOrderDone", regIdxT'(10 + j), '0, tags[j]);
        end
    end
    completeTag(tags[0], vals[0]);
    drainAndCheck("outOfOrderDone", 10, 4);
    for (int j = 0; j < 4; j++) begin
        expectReg("outOfOrderDone", regIdxT'(10 + j), vals[j], '0);
    end
endtask

task automatic renameOverwrite();
    tagT  t1;
    tagT  t2;
    tagT  tz;
    dataT v1;
    dataT v2;
    v1 = $urandom;
    v2 = $urandom;
    issueOne("renameOverwrite", 5'd7, t1);
    issueOne("renameOverwrite", 5'd7, t2);
    expectReg("renameOverwrite", 5'd7, '0, t2);
    // older writer lands its value but the younger one keeps r7
    completeTag(t1, v1);
    idle(1);
    expectReg("renameOverwrite", 5'd7, v1, t2);
    completeTag(t2, v2);
    idle(1);
    expectReg("renameOverwrite", 5'd7, v2, '0);
    // r0 stays zero through issue and completion
    issueOne("renameOverwrite", 5'd0, tz);
    expectReg("renameOverwrite", 5'd0, '0, '0);
    completeTag(tz, $urandom);
    idle(2);
    expectReg("renameOverwrite", 5'd0, '0, '0);
    checkStatus("renameOverwrite");
endtask

task automatic fullAndWrap();
    tagT  tags [robDepth];
    tagT  t;
    logic wrapped;
    for (int i = 0; i < robDepth; i++) begin
        issueOne("fullAndWrap", regIdxT'(16 + (i % 4)), tags[i]);
    end
    checkStatus("fullAndWrap");
    checkEq("fullAndWrap", "robFull when filled", 32'd1, 32'(robFull));
    for (int i = 0; i < robDepth; i++) begin
        completeTag(tags[i], $urandom);
    end
    drainAndCheck("fullAndWrap", 16, 4);
    checkEq("fullAndWrap", "robFull after drain", 32'd0, 32'(robFull));
    // push the counter past 63 with short issue and complete pairs
    wrapped = 1'b0;
    for (int i = 0; i < 70; i++) begin
        issueOne("fullAndWrap", regIdxT'(20 + (i % 4)), t);
        assert (issueTag != '0) else abortRun("issueTag took the reserved value 0");
        if (t == maxTag) begin
            checkEq("fullAndWrap", "issueTag after 63", 32'd1, 32'(issueTag));
            wrapped = 1'b1;
        end
        completeTag(t, $urandom);
    end
    drainAndCheck("fullAndWrap", 20, 4);
    assert (wrapped) else abortRun("issueTag never reached 63, so the wrap was not seen");
endtask

/* sim/renameCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module renameCoreTb;
    import renamePkg::*;

    localparam int numRead = 2;
    localparam int robDepth = 8;
    localparam int clkPeriod = 10;
    // cycle budget per test, the wrap test dominates
    localparam int testCycles = 35 + 10 + 30 + 25 + 340;
    localparam int marginCycles = 200;

    // one in-flight instruction as the model sees it
    typedef struct packed {
        regIdxT dest;
        tagT    tag;
        logic   fin;
        dataT   data;
    } modelEntryT;

    logic     clk;
    logic     rst;
    issueReqT issue;
    doneT     done;
    regIdxT   readReg [numRead];
    readRespT readResp [numRead];
    tagT      issueTag;
    logic     robFull;

    // reference model state
    dataT       modelVal [32];
    tagT        modelTag [32];
    tagT        modelNextTag;
    modelEntryT robQ [$];

    renameCore #(
        .numRead  (numRead),
        .robDepth (robDepth)
    ) dut0 (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .done     (done),
        .readReg  (readReg),
        .readResp (readResp),
        .issueTag (issueTag),
        .robFull  (robFull)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // reference model, steps on the same edge as the DUT
    always @(posedge clk) begin : refModel
        modelEntryT e;
        logic hit;
        if (rst) begin
            for (int r = 0; r < 32; r++) begin
                modelVal[r] = '0;
                modelTag[r] = '0;
            end
            robQ.delete();
            modelNextTag = 6'd1;
        end else begin
            // oldest entry leaves once its result is in
            if (robQ.size() > 0 && robQ[0].fin) begin
                e = robQ.pop_front();
                if (e.dest != '0) begin
                    modelVal[e.dest] = e.data;
                    // a younger writer keeps the reg pending
                    if (modelTag[e.dest] == e.tag) begin
                        modelTag[e.dest] = '0;
                    end
                end
            end
            // completion lands in its entry, commit waits for the next edge
            if (done.valid) begin
                hit = 1'b0;
                for (int k = 0; k < robQ.size(); k++) begin
                    if (!hit && !robQ[k].fin && robQ[k].tag == done.tag) begin
                        e = robQ[k];
                        e.fin = 1'b1;
                        e.data = done.data;
                        robQ[k] = e;
                        hit = 1'b1;
                    end
                end
            end
            // issue goes last so it owns the pending state
            if (issue.valid) begin
                robQ.push_back(modelEntryT'{dest: issue.dest, tag: modelNextTag,
                                            fin: 1'b0, data: '0});
                if (issue.dest != '0) begin
                    modelTag[issue.dest] = modelNextTag;
                end
                // tag 0 is never handed out
                if (modelNextTag == maxTag) begin
                    modelNextTag = 6'd1;
                end else begin
                    modelNextTag = modelNextTag + 6'd1;
                end
            end
        end
    end

    task automatic abortRun(string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic checkEq(string testName, string what, logic [31:0] expected,
                           logic [31:0] actual);
        assert (actual === expected) else
            abortRun($sformatf("error: %s: %s expected 0x%0h, actual 0x%0h",
                               testName, what, expected, actual));
    endtask

    // port 0 reads r, the other ports the regs just above it
    // so a crossed port shows up
    task automatic checkReg(string testName, regIdxT r);
        regIdxT addr [numRead];
        for (int p = 0; p < numRead; p++) begin
            addr[p] = r + regIdxT'(p);
            readReg[p] = addr[p];
        end
        #1;
        for (int p = 0; p < numRead; p++) begin
            checkEq(testName, $sformatf("r%0d data port %0d", addr[p], p),
                    modelVal[addr[p]], readResp[p].data);
            checkEq(testName, $sformatf("r%0d tag port %0d", addr[p], p),
                    32'(modelTag[addr[p]]), 32'(readResp[p].tag));
        end
    endtask

    // model check plus a value taken straight from the test
    task automatic expectReg(string testName, regIdxT r, dataT data, tagT tag);
        checkReg(testName, r);
        checkEq(testName, $sformatf("r%0d expected data", r), data, readResp[0].data);
        checkEq(testName, $sformatf("r%0d expected tag", r), 32'(tag), 32'(readResp[0].tag));
    endtask

    task automatic checkStatus(string testName);
        checkEq(testName, "issueTag", 32'(modelNextTag), 32'(issueTag));
        checkEq(testName, "robFull", 32'(robQ.size() == robDepth), 32'(robFull));
    endtask

    task automatic idle(int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic issueOne(string testName, regIdxT dest, output tagT tag);
        @(negedge clk);
        checkStatus(testName);
        assert (!robFull) else abortRun("issue blocked because the reorder buffer is full");
        tag = modelNextTag;
        issue.valid = 1'b1;
        issue.dest = dest;
        @(negedge clk);
        issue = '0;
    endtask

    task automatic completeTag(tagT tag, dataT value);
        @(negedge clk);
        done.valid = 1'b1;
        done.tag = tag;
        done.data = value;
        @(negedge clk);
        done = '0;
    endtask

    // idle until the model buffer empties, watching a few regs each cycle
    task automatic drainAndCheck(string testName, int firstReg, int numRegs);
        int waited;
        waited = 0;
        while (robQ.size() != 0) begin
            idle(1);
            for (int j = 0; j < numRegs; j++) begin
                checkReg(testName, regIdxT'(firstReg + j));
            end
            waited++;
            assert (waited <= robDepth + 4) else
                abortRun("reorder buffer did not drain in time");
        end
        checkStatus(testName);
    endtask

    `include "renameCoreTests.svh"

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        issue = '0;
        done = '0;
        readReg[0] = '0;
        readReg[1] = '0;
        void'($urandom(57));
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        resetState();
        issueAndCommit();
        outOfOrderDone();
        renameOverwrite();
        fullAndWrap();
        $display("STATUS: PASS");
        $finish;
    end

    // watchdog
    initial begin
        #((testCycles + marginCycles) * clkPeriod);
        abortRun("timeout, the tests did not finish in time");
    end

endmodule

`default_nettype wire

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = renameCoreTb
FILELIST = renameCore.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)
	-./$(OBJDIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* renameCore.f */
+incdir+sim
design/renamePkg.sv
design/regAliasTable.sv
design/reorderBuffer.sv
design/renameCore.sv
sim/renameCoreTb.sv
